// ==== hdl/io_overlay_pkg.sv ====
////////////////////
// IO overlay package
// Pin map, pad bundle types and JTAG tie-off values
////////////////////

`default_nettype none

package io_overlay_pkg;

  ////////////////////
  // Pad counts
  ////////////////////

  parameter int NumMio = 20;
  parameter int NumDio = 6;

  // Shared SPI pins within the dedicated vector
  parameter int DioSck = 0;
  parameter int DioCsb = 1;
  parameter int DioSdi = 2;
  parameter int DioSdo = 3;

  // Muxed pins with a fixed role on this target
  parameter int MioTrigger = 15;
  parameter int MioJtagEn  = 16;
  parameter int MioTrst    = 18;
  parameter int MioSrst    = 19;

  ////////////////////
  // Types
  ////////////////////

  // One bit per pad, dedicated pads on top
  typedef struct packed {
    logic [NumDio-1:0] dio;
    logic [NumMio-1:0] mio;
  } pad_bus_t;

  // Request side of the TAP
  typedef struct packed {
    logic tck;
    logic tms;
    logic trst_n;
    logic srst_n;
    logic tdi;
  } jtag_req_t;

  // Shared pins, LSB is DioSck
  typedef struct packed {
    logic sdo;
    logic sdi;
    logic csb;
    logic sck;
  } spi_pins_t;

  typedef struct packed {
    logic tdo;
    logic tdi;
    logic tms;
    logic tck;
  } jtag_pins_t;

  // Same four pins, SPI or JTAG view
  typedef union packed {
    spi_pins_t  spi;
    jtag_pins_t jtag;
  } shared_pins_u;

  ////////////////////
  // Tie-off values
  ////////////////////

  // Core view of taken-over pins, CSB stays deasserted
  parameter pad_bus_t JtagTieOff = '{dio: NumDio'(1 << DioCsb), mio: NumMio'(0)};

  // TAP held in reset, system reset released
  parameter jtag_req_t JtagInactive = '{tck: 1'b0, tms: 1'b0, trst_n: 1'b0,
                                        srst_n: 1'b1, tdi: 1'b0};

endpackage : io_overlay_pkg

`default_nettype wire

// ==== hdl/pad_in_sync.sv ====
////////////////////
// Pad input synchronizer
// Flop chain on every pad input bit
////////////////////

`timescale 1ns/1ps
`default_nettype none

module pad_in_sync #(
  // Chain depth, at least 1
  parameter int SyncStages = 2
) (
  // Clock and reset
  input  logic                     clk_main_i,
  input  logic                     arst_n_i,
  // Raw pin levels
  input  io_overlay_pkg::pad_bus_t pad_i,
  // Levels in the core clock domain
  output io_overlay_pkg::pad_bus_t pad_sync_o
);

  ////////////////////
  // Flop chain
  ////////////////////

  // Stage 0 samples the pins
  io_overlay_pkg::pad_bus_t [SyncStages-1:0] sync_q;

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      // First stage may go metastable
      sync_q[0] <= pad_i;
      // Remaining stages let it settle
      for (int i = 1; i < SyncStages; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // Last stage only
  assign pad_sync_o = sync_q[SyncStages-1];

endmodule : pad_in_sync

`default_nettype wire

// ==== hdl/jtag_overlay.sv ====
////////////////////
// JTAG overlay stage
// Strap hands the shared SPI pins and reset pins to the TAP
////////////////////

`timescale 1ns/1ps
`default_nettype none

module jtag_overlay (
  // Clock and reset
  input  logic                      clk_main_i,
  input  logic                      arst_n_i,
  // Synchronized pad levels
  input  io_overlay_pkg::pad_bus_t  pad_sync_i,
  // Core drive and enable
  input  io_overlay_pkg::pad_bus_t  core_out_i,
  input  io_overlay_pkg::pad_bus_t  core_oe_i,
  // TAP data out
  input  logic                      jtag_tdo_i,
  // Core side
  output io_overlay_pkg::pad_bus_t  core_in_o,
  output io_overlay_pkg::jtag_req_t jtag_o,
  // Pad side, before trigger gating
  output io_overlay_pkg::pad_bus_t  pad_out_o,
  output io_overlay_pkg::pad_bus_t  pad_oe_o
);

  ////////////////////
  // Pin masks
  ////////////////////

  // Pins the TAP drives into the chip
  localparam io_overlay_pkg::pad_bus_t InMask = '{
    dio: io_overlay_pkg::NumDio'((1 << io_overlay_pkg::DioSck) |
                                 (1 << io_overlay_pkg::DioCsb) |
                                 (1 << io_overlay_pkg::DioSdi)),
    mio: io_overlay_pkg::NumMio'((1 << io_overlay_pkg::MioTrst) |
                                 (1 << io_overlay_pkg::MioSrst))
  };

  // All six taken-over pins, TDO included
  localparam io_overlay_pkg::pad_bus_t TakenMask = '{
    dio: InMask.dio | io_overlay_pkg::NumDio'(1 << io_overlay_pkg::DioSdo),
    mio: InMask.mio
  };

  logic                         jtag_en;
  io_overlay_pkg::shared_pins_u shared;
  io_overlay_pkg::pad_bus_t     core_in_d, core_in_q;
  io_overlay_pkg::pad_bus_t     pad_out_d, pad_out_q;
  io_overlay_pkg::pad_bus_t     pad_oe_d, pad_oe_q;
  io_overlay_pkg::jtag_req_t    jtag_d, jtag_q;

  // Strap level, already synchronized
  assign jtag_en = pad_sync_i.mio[io_overlay_pkg::MioJtagEn];

  // Fill the SPI view, read back as JTAG
  always_comb begin
    shared.spi.sck = pad_sync_i.dio[io_overlay_pkg::DioSck];
    shared.spi.csb = pad_sync_i.dio[io_overlay_pkg::DioCsb];
    shared.spi.sdi = pad_sync_i.dio[io_overlay_pkg::DioSdi];
    shared.spi.sdo = pad_sync_i.dio[io_overlay_pkg::DioSdo];
  end

  ////////////////////
  // Overlay mux
  ////////////////////

  always_comb begin
    // Default is plain pass-through
    core_in_d = pad_sync_i;
    pad_out_d = core_out_i;
    pad_oe_d  = core_oe_i;
    jtag_d    = io_overlay_pkg::JtagInactive;
    if (jtag_en) begin
      jtag_d.tck    = shared.jtag.tck;
      jtag_d.tms    = shared.jtag.tms;
      jtag_d.tdi    = shared.jtag.tdi;
      jtag_d.trst_n = pad_sync_i.mio[io_overlay_pkg::MioTrst];
      jtag_d.srst_n = pad_sync_i.mio[io_overlay_pkg::MioSrst];
      // Core sees tie-offs on taken pins
      core_in_d = (pad_sync_i & ~TakenMask) | (io_overlay_pkg::JtagTieOff & TakenMask);
      // TAP inputs never driven
      pad_oe_d  = core_oe_i & ~InMask;
      // TDO owns the SDO pad
      pad_out_d.dio[io_overlay_pkg::DioSdo] = jtag_tdo_i;
      pad_oe_d.dio[io_overlay_pkg::DioSdo]  = 1'b1;
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      core_in_q <= '0;
      jtag_q    <= io_overlay_pkg::JtagInactive;
      pad_out_q <= '0;
      pad_oe_q  <= '0;
    end else begin
      core_in_q <= core_in_d;
      jtag_q    <= jtag_d;
      pad_out_q <= pad_out_d;
      pad_oe_q  <= pad_oe_d;
    end
  end

  assign core_in_o = core_in_q;
  assign jtag_o    = jtag_q;
  assign pad_out_o = pad_out_q;
  assign pad_oe_o  = pad_oe_q;

endmodule : jtag_overlay

`default_nettype wire

// ==== hdl/trigger_gate.sv ====
////////////////////
// Capture trigger gate
// Trigger pin only toggles while crypto is busy
////////////////////

`timescale 1ns/1ps
`default_nettype none

module trigger_gate (
  // Clock and reset
  input  logic                     clk_main_i,
  input  logic                     arst_n_i,
  // Pre-gate pad drive
  input  io_overlay_pkg::pad_bus_t pad_out_i,
  input  io_overlay_pkg::pad_bus_t pad_oe_i,
  // Crypto block activity
  input  logic                     crypto_busy_i,
  // To the pads
  output io_overlay_pkg::pad_bus_t pad_out_o,
  output io_overlay_pkg::pad_bus_t pad_oe_o
);

  logic                     busy_q;
  io_overlay_pkg::pad_bus_t pad_out_d, pad_out_q;
  io_overlay_pkg::pad_bus_t pad_oe_q;

  // Software trigger masked by busy, rest untouched
  always_comb begin
    pad_out_d = pad_out_i;
    pad_out_d.mio[io_overlay_pkg::MioTrigger] =
        pad_out_i.mio[io_overlay_pkg::MioTrigger] & busy_q;
  end

  ////////////////////
  // Registers
  ////////////////////

  // Busy delayed to match the overlay stage
  always_ff @(posedge clk_main_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      pad_out_q <= '0;
      pad_oe_q  <= '0;
    end else begin
      busy_q    <= crypto_busy_i;
      pad_out_q <= pad_out_d;
      pad_oe_q  <= pad_oe_i;
    end
  end

  assign pad_out_o = pad_out_q;
  assign pad_oe_o  = pad_oe_q;

endmodule : trigger_gate

`default_nettype wire

// ==== hdl/io_overlay_top.sv ====
////////////////////
// IO overlay top
// Synchronizer, JTAG overlay and trigger gate in a row
////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_overlay_top #(
  // Depth of the input synchronizer
  parameter int SyncStages = 2
) (
  // Clock and reset
  input  logic                      clk_main_i,
  input  logic                      arst_n_i,
  // Pad side
  input  io_overlay_pkg::pad_bus_t  pad_in_i,
  output io_overlay_pkg::pad_bus_t  pad_out_o,
  output io_overlay_pkg::pad_bus_t  pad_oe_o,
  // Core side
  input  io_overlay_pkg::pad_bus_t  core_out_i,
  input  io_overlay_pkg::pad_bus_t  core_oe_i,
  output io_overlay_pkg::pad_bus_t  core_in_o,
  // TAP
  output io_overlay_pkg::jtag_req_t jtag_o,
  input  logic                      jtag_tdo_i,
  // Crypto block busy, for capture
  input  logic                      crypto_busy_i
);

  // Between the stages
  io_overlay_pkg::pad_bus_t pad_sync;
  io_overlay_pkg::pad_bus_t pad_out_pre;
  io_overlay_pkg::pad_bus_t pad_oe_pre;

  ////////////////////
  // Input sync
  ////////////////////

  pad_in_sync #(
    .SyncStages ( SyncStages )
  ) i_pad_in_sync (
    .clk_main_i ( clk_main_i ),
    .arst_n_i   ( arst_n_i   ),
    .pad_i      ( pad_in_i   ),
    .pad_sync_o ( pad_sync   )
  );

  ////////////////////
  // JTAG overlay
  ////////////////////

  jtag_overlay i_jtag_overlay (
    .clk_main_i ( clk_main_i  ),
    .arst_n_i   ( arst_n_i    ),
    .pad_sync_i ( pad_sync    ),
    .core_out_i ( core_out_i  ),
    .core_oe_i  ( core_oe_i   ),
    .jtag_tdo_i ( jtag_tdo_i  ),
    .core_in_o  ( core_in_o   ),
    .jtag_o     ( jtag_o      ),
    .pad_out_o  ( pad_out_pre ),
    .pad_oe_o   ( pad_oe_pre  )
  );

  ////////////////////
  // Capture trigger
  ////////////////////

  trigger_gate i_trigger_gate (
    .clk_main_i    ( clk_main_i    ),
    .arst_n_i      ( arst_n_i      ),
    .pad_out_i     ( pad_out_pre   ),
    .pad_oe_i      ( pad_oe_pre    ),
    .crypto_busy_i ( crypto_busy_i ),
    .pad_out_o     ( pad_out_o     ),
    .pad_oe_o      ( pad_oe_o      )
  );

endmodule : io_overlay_top

`default_nettype wire

// ==== sim/io_overlay_chk.sv ====
////////////////////
// JTAG overlay checker
// Assertions on the registered overlay outputs
////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_overlay_chk (
  input logic                      clk_main_i,
  input logic                      arst_n_i,
  input io_overlay_pkg::pad_bus_t  pad_sync_i,
  input io_overlay_pkg::pad_bus_t  pad_oe_i,
  input io_overlay_pkg::pad_bus_t  core_in_i,
  input io_overlay_pkg::jtag_req_t jtag_i
);

  logic        jtag_en;
  int unsigned oe_fails  = 0;
  int unsigned req_fails = 0;
  int unsigned rst_fails = 0;
  int unsigned fail_cnt;

  // Strap as the overlay sees it
  assign jtag_en  = pad_sync_i.mio[io_overlay_pkg::MioJtagEn];
  assign fail_cnt = oe_fails + req_fails + rst_fails;

  // TAP inputs undriven, TDO pad driven
  oe_in_jtag: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    jtag_en |=> (pad_oe_i.dio[io_overlay_pkg::DioSck] == 1'b0 &&
                 pad_oe_i.dio[io_overlay_pkg::DioCsb] == 1'b0 &&
                 pad_oe_i.dio[io_overlay_pkg::DioSdi] == 1'b0 &&
                 pad_oe_i.mio[io_overlay_pkg::MioTrst] == 1'b0 &&
                 pad_oe_i.mio[io_overlay_pkg::MioSrst] == 1'b0 &&
                 pad_oe_i.dio[io_overlay_pkg::DioSdo] == 1'b1))
  else begin
    $error("Pad enables wrong in JTAG mode");
    oe_fails++;
  end

  // No TAP activity without the strap
  req_idle: assert property (@(posedge clk_main_i) disable iff (!arst_n_i)
    !jtag_en |=> jtag_i == io_overlay_pkg::JtagInactive)
  else begin
    $error("JTAG request active outside JTAG mode");
    req_fails++;
  end

  // Reset value seen at the first edge after release
  core_in_rst: assert property (@(posedge clk_main_i) $rose(arst_n_i) |-> core_in_i == '0)
  else begin
    $error("Core input bundle left reset value early");
    rst_fails++;
  end

endmodule : io_overlay_chk

`default_nettype wire

// ==== sim/io_overlay_tb.sv ====
////////////////////
// IO overlay testbench
// Random pad and core traffic checked against a reference model
////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_overlay_tb;

  // One cycle of applied inputs
  typedef struct packed {
    io_overlay_pkg::pad_bus_t pad_in;
    io_overlay_pkg::pad_bus_t core_out;
    io_overlay_pkg::pad_bus_t core_oe;
    logic                     tdo;
    logic                     busy;
  } stim_t;

  // Expected DUT outputs for one cycle
  typedef struct packed {
    io_overlay_pkg::pad_bus_t  core_in;
    io_overlay_pkg::jtag_req_t jtag;
    io_overlay_pkg::pad_bus_t  pad_out;
    io_overlay_pkg::pad_bus_t  pad_oe;
  } exp_t;

  // TAP held in reset and system reset released
  localparam io_overlay_pkg::jtag_req_t JtagIdle = '{tck: 1'b0, tms: 1'b0, trst_n: 1'b0,
                                                     srst_n: 1'b1, tdi: 1'b0};

  logic                      clk = 1'b0;
  logic                      arst_n;
  io_overlay_pkg::pad_bus_t  pad_in, pad_out, pad_oe;
  io_overlay_pkg::pad_bus_t  core_out, core_oe, core_in;
  io_overlay_pkg::jtag_req_t jtag;
  logic                      jtag_tdo;
  logic                      crypto_busy;

  logic [31:0] rng = 32'hb8ef_2f60;
  stim_t       hist[$];
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned cycles_driven = 0;
  int unsigned cycles_checked = 0;
  int unsigned post_rst = 0;

  io_overlay_top #(
    .SyncStages ( 2 )
  ) i_dut (
    .clk_main_i    ( clk         ),
    .arst_n_i      ( arst_n      ),
    .pad_in_i      ( pad_in      ),
    .pad_out_o     ( pad_out     ),
    .pad_oe_o      ( pad_oe      ),
    .core_out_i    ( core_out    ),
    .core_oe_i     ( core_oe     ),
    .core_in_o     ( core_in     ),
    .jtag_o        ( jtag        ),
    .jtag_tdo_i    ( jtag_tdo    ),
    .crypto_busy_i ( crypto_busy )
  );

  // Overlay assertions
  bind jtag_overlay io_overlay_chk i_chk (
    .clk_main_i ( clk_main_i ),
    .arst_n_i   ( arst_n_i   ),
    .pad_sync_i ( pad_sync_i ),
    .pad_oe_i   ( pad_oe_o   ),
    .core_in_i  ( core_in_o  ),
    .jtag_i     ( jtag_o     )
  );

  // 8 ns period
  always #4 clk = ~clk;

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Random cycle with the strap pin forced
  function automatic stim_t random_stim(input logic strap);
    stim_t       s;
    logic [31:0] r;
    r = next_rand();
    s.pad_in = r[25:0];
    s.pad_in.mio[io_overlay_pkg::MioJtagEn] = strap;
    r = next_rand();
    s.core_out = r[25:0];
    s.tdo      = r[31];
    s.busy     = r[30];
    r = next_rand();
    s.core_oe = r[25:0];
    return s;
  endfunction

  // Expected outputs from the input 3 back, the core side 2 back and the strap 4 back
  function automatic exp_t ref_model(input stim_t in_s, input stim_t out_s,
                                     input logic out_jtag);
    io_overlay_pkg::shared_pins_u pins;
    exp_t                         e;
    e.core_in = in_s.pad_in;
    e.jtag    = JtagIdle;
    if (in_s.pad_in.mio[io_overlay_pkg::MioJtagEn]) begin
      // Word built as SPI pins and read back as TAP pins
      pins = {in_s.pad_in.dio[io_overlay_pkg::DioSdo], in_s.pad_in.dio[io_overlay_pkg::DioSdi],
              in_s.pad_in.dio[io_overlay_pkg::DioCsb], in_s.pad_in.dio[io_overlay_pkg::DioSck]};
      e.jtag.tck    = pins.jtag.tck;
      e.jtag.tms    = pins.jtag.tms;
      e.jtag.tdi    = pins.jtag.tdi;
      e.jtag.trst_n = in_s.pad_in.mio[io_overlay_pkg::MioTrst];
      e.jtag.srst_n = in_s.pad_in.mio[io_overlay_pkg::MioSrst];
      // Core sees CSB high and the others low
      e.core_in.dio[io_overlay_pkg::DioSck]  = 1'b0;
      e.core_in.dio[io_overlay_pkg::DioCsb]  = 1'b1;
      e.core_in.dio[io_overlay_pkg::DioSdi]  = 1'b0;
      e.core_in.dio[io_overlay_pkg::DioSdo]  = 1'b0;
      e.core_in.mio[io_overlay_pkg::MioTrst] = 1'b0;
      e.core_in.mio[io_overlay_pkg::MioSrst] = 1'b0;
    end
    e.pad_out = out_s.core_out;
    e.pad_oe  = out_s.core_oe;
    if (out_jtag) begin
      e.pad_oe.dio[io_overlay_pkg::DioSck]  = 1'b0;
      e.pad_oe.dio[io_overlay_pkg::DioCsb]  = 1'b0;
      e.pad_oe.dio[io_overlay_pkg::DioSdi]  = 1'b0;
      e.pad_oe.mio[io_overlay_pkg::MioTrst] = 1'b0;
      e.pad_oe.mio[io_overlay_pkg::MioSrst] = 1'b0;
      e.pad_out.dio[io_overlay_pkg::DioSdo] = out_s.tdo;
      e.pad_oe.dio[io_overlay_pkg::DioSdo]  = 1'b1;
    end
    // Capture trigger only while busy
    e.pad_out.mio[io_overlay_pkg::MioTrigger] =
        out_s.core_out.mio[io_overlay_pkg::MioTrigger] & out_s.busy;
    return e;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0d ns: %s mismatch, got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Drive one cycle 1 ns after the edge
  task automatic apply_stim(input stim_t s, input logic held);
    @(posedge clk);
    #1;
    pad_in      = s.pad_in;
    core_out    = s.core_out;
    core_oe     = s.core_oe;
    jtag_tdo    = s.tdo;
    crypto_busy = s.busy;
    // Flops still in reset act as if fed zeros
    if (held) begin
      hist.push_back('0);
    end else begin
      hist.push_back(s);
    end
    if (hist.size() > 8) begin
      void'(hist.pop_front());
    end
    cycles_driven++;
  endtask

  task automatic wait_checks(input int unsigned limit, output logic timed_out);
    int unsigned n;
    n = 0;
    while (cycles_checked < cycles_driven && n < limit) begin
      @(negedge clk);
      n++;
    end
    timed_out = (cycles_checked < cycles_driven);
  endtask

  ////////////////////
  // Compare
  ////////////////////

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    int   last;
    exp_t e;
    if (cycles_checked < cycles_driven) begin
      last = hist.size() - 1;
      e = ref_model(hist[last-3], hist[last-2],
                    hist[last-4].pad_in.mio[io_overlay_pkg::MioJtagEn]);
      check_val("core_in_o", {6'd0, core_in}, {6'd0, e.core_in});
      check_val("jtag_o", {27'd0, jtag}, {27'd0, e.jtag});
      check_val("pad_out_o", {6'd0, pad_out}, {6'd0, e.pad_out});
      check_val("pad_oe_o", {6'd0, pad_oe}, {6'd0, e.pad_oe});
      // Reset values in reset and just after release
      if (!arst_n || post_rst < 3) begin
        check_val("pad_out_o at reset", {6'd0, pad_out}, 32'd0);
        check_val("pad_oe_o at reset", {6'd0, pad_oe}, 32'd0);
        check_val("jtag_o at reset", {27'd0, jtag}, {27'd0, JtagIdle});
      end
      if (arst_n) begin
        post_rst++;
      end
      cycles_checked++;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    int          i;
    logic [31:0] r;
    logic        strap;
    logic        timed_out;
    int unsigned assert_fails;
    pad_in      = '0;
    core_out    = '0;
    core_oe     = '0;
    jtag_tdo    = 1'b0;
    crypto_busy = 1'b0;
    arst_n      = 1'b0;
    // Pipeline holds reset values before the first edge
    for (i = 0; i < 4; i++) begin
      hist.push_back('0);
    end
    // Random pins while in reset
    for (i = 0; i < 15; i++) begin
      r = next_rand();
      apply_stim(random_stim(r[0]), 1'b1);
    end
    // Sampled on the first edge after release
    apply_stim('0, 1'b0);
    arst_n = 1'b1;
    for (i = 0; i < 4; i++) begin
      apply_stim('0, 1'b0);
    end
    // Plain pass-through with the strap low
    for (i = 0; i < 300; i++) begin
      apply_stim(random_stim(1'b0), 1'b0);
    end
    // JTAG overlay with the strap high
    for (i = 0; i < 300; i++) begin
      apply_stim(random_stim(1'b1), 1'b0);
    end
    // Strap toggles now and then
    strap = 1'b0;
    for (i = 0; i < 2000; i++) begin
      r = next_rand();
      if (r[2:0] == 3'd0) begin
        strap = ~strap;
      end
      apply_stim(random_stim(strap), 1'b0);
    end
    wait_checks(20, timed_out);
    assert_fails = i_dut.i_jtag_overlay.i_chk.fail_cnt;
    if (timed_out) begin
      $display("Timeout: compare process did not check every driven cycle");
    end
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, assert_fails);
    if (!timed_out && errors == 0 && assert_fails == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : io_overlay_tb

`default_nettype wire

// ==== flist.f ====
hdl/io_overlay_pkg.sv
hdl/pad_in_sync.sv
hdl/jtag_overlay.sv
hdl/trigger_gate.sv
hdl/io_overlay_top.sv
sim/io_overlay_chk.sv
sim/io_overlay_tb.sv

// ==== Makefile ====
# Verilator flow for the IO overlay testbench

TOP := io_overlay_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
